// ==== source/golay24_functions.svh ====
  // Divides the 23-bit polynomial v by g(x) = 12'hC75, bit i being the x^i term.
  // The low 11 bits of the result are the remainder.
  // Bit 11 is the even parity of the remainder together with v.
  // For an encoder word, v holds the data shifted up by 11, which gives the check bits.
  function automatic logic [11:0] get_syndrome(input logic [22:0] v);
    logic [22:0] r;
    r = v;
    for (int i = 22; i >= 11; i--) begin
      if (r[i]) begin
        r[i -: 12] = r[i -: 12] ^ 12'hC75; // Subtract the generator under the leading term.
      end
    end
    return {^{r[10:0], v}, r[10:0]};
  endfunction

  // Even parity over the whole 24-bit word, so a valid codeword gives zero.
  function automatic logic get_parity(input golay_code_t w);
    return ^w;
  endfunction

  // Maps every syndrome to the single error pattern of weight three or less.
  // The perfect code means each of the 2048 entries is hit exactly once.
  function automatic err_tab_t build_err_table();
    err_tab_t   tab;
    golay_err_t e;
    logic [11:0] s;
    tab = '{default: '0}; // Syndrome zero keeps the empty pattern.
    // Equal indices collapse, so one nest covers weights one, two and three.
    for (int a = 0; a < 23; a++) begin
      for (int b = a; b < 23; b++) begin
        for (int c = b; c < 23; c++) begin
          e = (golay_err_t'(1) << a) | (golay_err_t'(1) << b) | (golay_err_t'(1) << c);
          s = get_syndrome(e);
          tab[s[10:0]] = e;
        end
      end
    end
    return tab;
  endfunction

// ==== source/golay24_pkg.sv ====
`default_nettype none

package golay24_pkg;

  // Twelve information bits as they enter the encoder.
  typedef logic [11:0] golay_data_t;

  // Full extended codeword, also the width of the shared result bus.
  typedef logic [23:0] golay_code_t;

  // Remainder of a 23-bit word divided by the generator.
  typedef logic [10:0] golay_syn_t;

  // Number of bits the decoder corrected.
  typedef logic [1:0] err_cnt_t;

  // Output credit counter, wide enough for seven credits.
  typedef logic [2:0] credit_t;

  // Error pattern over the 23 cyclic bits, and the table indexed by syndrome.
  typedef logic [22:0] golay_err_t;
  typedef golay_err_t err_tab_t [2048];

  // Last winner of the bus, reused as the result kind tag.
  typedef enum logic {
    OWNER_ENC = 1'b0,
    OWNER_DEC = 1'b1
  } owner_e;

  localparam int PEER_DEPTH = 2; // Words a peer can hold, equal to its input credits.

endpackage

`default_nettype wire

// ==== source/golay_peer_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// One peer's result slot as seen by the output arbiter.
interface golay_peer_if #(
  parameter int pTAG_W = 4
);
  import golay24_pkg::*;

  logic              val;   // A result is waiting.
  logic [pTAG_W-1:0] tag;   // Tag that came in with the word.
  golay_code_t       dat;   // Codeword or packed decoder result.
  logic              grant; // The word is taken in this cycle.

  // The peer holds val, tag and dat steady until grant.
  modport peer (output val, output tag, output dat, input grant);

  modport arb (input val, input tag, input dat, output grant);

endinterface

`default_nettype wire

// ==== source/golay24_enc.sv ====
`timescale 1ns/10ps
`default_nettype none

module golay24_enc #(
  parameter int pTAG_W = 4
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     ival,
  input  logic [pTAG_W-1:0]        itag,
  input  golay24_pkg::golay_data_t idat,
  output logic                     credit, // One pulse per result that leaves.
  golay_peer_if.peer               peer
);
  import golay24_pkg::*;

  `include "golay24_functions.svh"

  logic              stall;  // Result is valid but not taken this cycle.
  logic              s1_en;  // Stage one may load.
  logic [11:0]       chk;    // Parity bit over the eleven cyclic check bits.
  logic              s1_val;
  logic [pTAG_W-1:0] s1_tag;
  golay_code_t       s1_dat;

  assign stall  = peer.val & ~peer.grant;
  assign s1_en  = ~stall | ~s1_val; // An empty first stage still takes a word during a stall.
  assign credit = peer.grant;       // The slot frees up as the word is granted.

  // Check bits are the remainder of data times x^11, which sits in bits 22:12.
  assign chk = get_syndrome({idat, 11'b0});

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_val   <= 1'b0;
      peer.val <= 1'b0;
    end else begin
      if (s1_en) s1_val <= ival;
      if (!stall) peer.val <= s1_val;
    end
  end

  // Payload registers only follow their valid bits.
  always_ff @(posedge iclk) begin
    if (s1_en) begin
      s1_tag <= itag;
      s1_dat <= {chk, idat}; // Data stays in bits 11:0.
    end
    if (!stall) begin
      peer.tag <= s1_tag;
      peer.dat <= s1_dat;
    end
  end

endmodule

`default_nettype wire

// ==== source/golay24_dec.sv ====
`timescale 1ns/10ps
`default_nettype none

module golay24_dec #(
  parameter int pTAG_W = 4
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     ival,
  input  logic [pTAG_W-1:0]        itag,
  input  golay24_pkg::golay_code_t idat,
  output logic                     credit, // One pulse per result that leaves.
  golay_peer_if.peer               peer
);
  import golay24_pkg::*;

  `include "golay24_functions.svh"

  // Syndrome to error pattern, built once at elaboration.
  localparam err_tab_t ERR_TAB = build_err_table();

  logic              stall;
  logic              s1_en;
  logic [11:0]       in_rem;  // Remainder of the received cyclic bits.
  logic              s1_val;
  logic [pTAG_W-1:0] s1_tag;
  golay_code_t       s1_word; // Word as received.
  golay_syn_t        s1_syn;
  logic              s1_q;    // One when an odd number of bits flipped.
  golay_err_t        pat;
  err_cnt_t          w;       // Weight of the pattern from the table.
  golay_err_t        fixed;
  err_cnt_t          cnt;
  logic              unc;
  golay_data_t       data_out;

  assign stall  = peer.val & ~peer.grant;
  assign s1_en  = ~stall | ~s1_val;
  assign credit = peer.grant;
  assign in_rem = get_syndrome(idat[22:0]);

  // The table holds the only pattern of weight three or less for each syndrome.
  assign pat   = ERR_TAB[s1_syn];
  assign w     = err_cnt_t'($countones(pat));
  assign fixed = s1_word[22:0] ^ pat;

  // The overall parity tells whether bit 23 was hit as well.
  always_comb begin
    unc      = 1'b0;
    cnt      = w;
    data_out = fixed[11:0];
    if (s1_q != w[0]) begin
      if (w != 2'd3) begin
        cnt = w + 2'd1; // The parity bit itself was the extra error.
      end else begin
        unc      = 1'b1; // Four errors, so nothing is corrected.
        cnt      = '0;
        data_out = s1_word[11:0];
      end
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      s1_val   <= 1'b0;
      peer.val <= 1'b0;
    end else begin
      if (s1_en) s1_val <= ival;
      if (!stall) peer.val <= s1_val;
    end
  end

  always_ff @(posedge iclk) begin
    if (s1_en) begin
      s1_tag  <= itag;
      s1_word <= idat;
      s1_syn  <= in_rem[10:0];
      s1_q    <= get_parity(idat);
    end
    if (!stall) begin
      peer.tag <= s1_tag;
      peer.dat <= {9'b0, unc, cnt, data_out}; // Flag in bit 14 and count in bits 13:12.
    end
  end

endmodule

`default_nettype wire

// ==== source/golay24_out_arb.sv ====
`timescale 1ns/10ps
`default_nettype none

module golay24_out_arb #(
  parameter int pTAG_W       = 4,
  parameter int pOUT_CREDITS = 4
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     credit_in, // Single-cycle credit return from the sink.
  golay_peer_if.arb                enc_side,
  golay_peer_if.arb                dec_side,
  output logic                     out_val,
  output golay24_pkg::owner_e      out_kind,
  output logic [pTAG_W-1:0]        out_tag,
  output golay24_pkg::golay_code_t out_dat
);
  import golay24_pkg::*;

  credit_t credits;  // Words the sink can still accept.
  owner_e  last;     // Peer that won the bus most recently.
  logic    avail;
  logic    pick_enc; // Encoder wins if it is the only one or it is its turn.
  logic    take;

  // A credit arriving this cycle may be spent at once.
  assign avail = (credits != '0) | credit_in;

  assign pick_enc = enc_side.val & (~dec_side.val | (last == OWNER_DEC));

  assign enc_side.grant = avail & pick_enc;
  assign dec_side.grant = avail & dec_side.val & ~pick_enc;
  assign take           = enc_side.grant | dec_side.grant;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      out_val <= 1'b0;
      credits <= credit_t'(pOUT_CREDITS);
      last    <= OWNER_DEC; // The encoder gets the first turn.
    end else begin
      out_val <= take;
      // Spend one per word sent and gain one per returned pulse.
      credits <= credits - credit_t'(take) + credit_t'(credit_in);
      if (take) last <= pick_enc ? OWNER_ENC : OWNER_DEC;
    end
  end

  // The granted word moves onto the bus one edge after its grant.
  always_ff @(posedge iclk) begin
    if (take) begin
      if (pick_enc) begin
        out_kind <= OWNER_ENC;
        out_tag  <= enc_side.tag;
        out_dat  <= enc_side.dat;
      end else begin
        out_kind <= OWNER_DEC;
        out_tag  <= dec_side.tag;
        out_dat  <= dec_side.dat;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/golay24_codec_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module golay24_codec_top #(
  parameter int pTAG_W       = 4,
  parameter int pOUT_CREDITS = 4
) (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     enc_val,
  input  logic [pTAG_W-1:0]        enc_tag,
  input  golay24_pkg::golay_data_t enc_dat,
  output logic                     enc_credit,
  input  logic                     dec_val,
  input  logic [pTAG_W-1:0]        dec_tag,
  input  golay24_pkg::golay_code_t dec_dat,
  output logic                     dec_credit,
  output logic                     out_val,
  output golay24_pkg::owner_e      out_kind,
  output logic [pTAG_W-1:0]        out_tag,
  output golay24_pkg::golay_code_t out_dat,
  input  logic                     out_credit
);

  // One result slot per channel between the peer and the arbiter.
  golay_peer_if #(.pTAG_W(pTAG_W)) enc_if ();
  golay_peer_if #(.pTAG_W(pTAG_W)) dec_if ();

  golay24_enc #(.pTAG_W(pTAG_W)) u_enc (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (enc_val),
    .itag   (enc_tag),
    .idat   (enc_dat),
    .credit (enc_credit),
    .peer   (enc_if.peer)
  );

  golay24_dec #(.pTAG_W(pTAG_W)) u_dec (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (dec_val),
    .itag   (dec_tag),
    .idat   (dec_dat),
    .credit (dec_credit),
    .peer   (dec_if.peer)
  );

  // Both channels share the result bus and its credits.
  golay24_out_arb #(.pTAG_W(pTAG_W), .pOUT_CREDITS(pOUT_CREDITS)) u_arb (
    .iclk      (iclk),
    .ireset    (ireset),
    .credit_in (out_credit),
    .enc_side  (enc_if.arb),
    .dec_side  (dec_if.arb),
    .out_val   (out_val),
    .out_kind  (out_kind),
    .out_tag   (out_tag),
    .out_dat   (out_dat)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

// Free-running clock and a reset that drops on a falling edge.
module tb_clock #(
  parameter int pPERIOD       = 20,
  parameter int pRESET_CYCLES = 5
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(pPERIOD / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (pRESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0; // Released half a cycle before the next rising edge.
  end

endmodule

`default_nettype wire

// ==== bench/golay24_tb_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module golay24_tb_sva #(
  parameter int pOUT_CREDITS = 4
) (
  input logic                     iclk,
  input logic                     ireset,
  input logic                     out_val,
  input logic                     out_credit,
  input logic                     enc_val,
  input logic                     enc_grant,
  input golay24_pkg::golay_code_t enc_dat,
  input logic                     dec_val,
  input logic                     dec_grant,
  input golay24_pkg::golay_code_t dec_dat
);

  int bal; // Credits the sink has handed out minus words it has seen.

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      bal <= pOUT_CREDITS;
    end else begin
      bal <= bal + int'(out_credit) - int'(out_val);
    end
  end

  // The bus stays quiet through reset and the cycle after it.
  a_reset_quiet: assert property (@(posedge iclk) ireset |=> !out_val)
    else $error("out_val high during or right after reset");

  a_out_credit: assert property (@(posedge iclk) disable iff (ireset) out_val |-> bal > 0)
    else $error("out_val without an output credit");

  // A word waiting for its grant must not move or vanish.
  a_enc_hold: assert property (@(posedge iclk) disable iff (ireset)
    enc_val && !enc_grant |=> enc_val && $stable(enc_dat))
    else $error("encoder result changed while not granted");

  a_dec_hold: assert property (@(posedge iclk) disable iff (ireset)
    dec_val && !dec_grant |=> dec_val && $stable(dec_dat))
    else $error("decoder result changed while not granted");

endmodule

`default_nettype wire

// ==== bench/golay24_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module golay24_tb;
  import golay24_pkg::*;

  localparam int TAG_W       = 4;
  localparam int OUT_CREDITS = 4;
  localparam int WORDS       = 300;            // Words sent on each channel.
  localparam int MAX_CYCLES  = 2 * WORDS * 20; // Twenty cycles of margin per word.

  typedef logic [TAG_W-1:0] tag_t;

  logic        iclk;
  logic        ireset;
  logic        enc_val;
  tag_t        enc_tag;
  golay_data_t enc_dat;
  logic        enc_credit;
  logic        dec_val;
  tag_t        dec_tag;
  golay_code_t dec_dat;
  logic        dec_credit;
  logic        out_val;
  owner_e      out_kind;
  tag_t        out_tag;
  golay_code_t out_dat;
  logic        out_credit;

  logic [31:0] rng;
  int          enc_sent, dec_sent;         // Words handed to each channel.
  int          enc_got, dec_got;           // Results seen on the bus.
  int          enc_returned, dec_returned; // Input credit pulses, counted on rising edges.
  int          sink_cnt;                   // Credits the arbiter may still spend.
  int          owed;                       // Words the sink has not yet paid back.
  int          cyc;
  golay_code_t enc_exp[$], dec_exp[$];
  tag_t        enc_tag_q[$], dec_tag_q[$];

  tb_clock #(.pPERIOD(20), .pRESET_CYCLES(5)) u_clock (.clk(iclk), .reset(ireset));

  golay24_codec_top #(.pTAG_W(TAG_W), .pOUT_CREDITS(OUT_CREDITS)) DUT (.*);

  bind golay24_codec_top golay24_tb_sva #(.pOUT_CREDITS(pOUT_CREDITS)) u_sva (
    .iclk       (iclk),
    .ireset     (ireset),
    .out_val    (out_val),
    .out_credit (out_credit),
    .enc_val    (enc_if.val),
    .enc_grant  (enc_if.grant),
    .enc_dat    (enc_if.dat),
    .dec_val    (dec_if.val),
    .dec_grant  (dec_if.grant),
    .dec_dat    (dec_if.dat)
  );

  // Xorshift32 step on the shared generator state.
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // An LFSR divides data times x^11 by g(x), feeding the data MSB first.
  function automatic golay_code_t golay_encode(input golay_data_t d);
    logic [10:0] rem;
    logic        fb;
    golay_code_t cw;
    rem = '0;
    for (int i = 11; i >= 0; i--) begin
      fb  = rem[10] ^ d[i];
      rem = {rem[9:0], 1'b0};
      if (fb) rem = rem ^ 11'h475; // The x^10..x^0 terms of 12'hC75.
    end
    cw     = {1'b0, rem, d};
    cw[23] = ^cw[22:0]; // Even parity over the whole word.
    return cw;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_code(input golay_code_t got, input golay_code_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at %0t: %s word %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_tag(input tag_t got, input tag_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH at %0t: %s tag %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  // Bus outputs are stable at the falling edge, one registered word at most.
  task automatic take_result();
    if (out_val) begin
      if (sink_cnt == 0) report_failure("Result sent while the sink had no credit left.");
      sink_cnt--;
      owed++;
      if (out_kind == OWNER_ENC) begin
        if (enc_exp.size() == 0) report_failure("Encoder result arrived with none outstanding.");
        check_code(out_dat, enc_exp.pop_front(), "encoder");
        check_tag(out_tag, enc_tag_q.pop_front(), "encoder");
        enc_got++;
        if (enc_returned < enc_got) report_failure("Encoder result left without a credit pulse.");
      end else begin
        if (dec_exp.size() == 0) report_failure("Decoder result arrived with none outstanding.");
        check_code(out_dat, dec_exp.pop_front(), "decoder");
        check_tag(out_tag, dec_tag_q.pop_front(), "decoder");
        dec_got++;
        if (dec_returned < dec_got) report_failure("Decoder result left without a credit pulse.");
      end
    end
  endtask

  task automatic drive_enc();
    logic [31:0] r;
    golay_data_t d;
    tag_t        t;
    enc_val = 1'b0;
    r       = next_rand();
    if (enc_sent < WORDS && enc_sent - enc_returned < PEER_DEPTH && r[1:0] != 2'b00) begin
      d       = golay_data_t'(next_rand());
      t       = tag_t'(next_rand());
      enc_val = 1'b1;
      enc_tag = t;
      enc_dat = d;
      enc_exp.push_back(golay_encode(d));
      enc_tag_q.push_back(t);
      enc_sent++;
    end
  endtask

  // A codeword with k distinct bits flipped, k = 4 in about one word in ten.
  task automatic drive_dec();
    logic [31:0] r;
    golay_data_t d;
    golay_code_t flips;
    golay_code_t rx;
    tag_t        t;
    int          k;
    dec_val = 1'b0;
    r       = next_rand();
    if (dec_sent < WORDS && dec_sent - dec_returned < PEER_DEPTH && r[1:0] != 2'b00) begin
      d     = golay_data_t'(next_rand());
      t     = tag_t'(next_rand());
      k     = (next_rand() % 10 == 0) ? 4 : int'(next_rand() % 4);
      flips = '0;
      while ($countones(flips) < k) flips[int'(next_rand() % 24)] = 1'b1;
      rx      = golay_encode(d) ^ flips;
      dec_val = 1'b1;
      dec_tag = t;
      dec_dat = rx;
      if (k == 4) dec_exp.push_back({9'b0, 1'b1, 2'b00, rx[11:0]}); // Raw data, flagged.
      else dec_exp.push_back({9'b0, 1'b0, err_cnt_t'(k), d});
      dec_tag_q.push_back(t);
      dec_sent++;
    end
  endtask

  task automatic drive_sink();
    logic [31:0] r;
    out_credit = 1'b0;
    r          = next_rand();
    // The last quarter of every 256 cycles holds credits back to stall both channels.
    if (owed > 0 && cyc % 256 < 192 && r[2:0] < 3'd3) begin
      out_credit = 1'b1;
      owed--;
      sink_cnt++;
    end
  endtask

  always @(posedge iclk) begin
    if (enc_credit) enc_returned++;
    if (dec_credit) dec_returned++;
  end

  initial begin
    rng        = 32'h24e0_0b3d;
    sink_cnt   = OUT_CREDITS;
    enc_val    = 1'b0;
    enc_tag    = '0;
    enc_dat    = '0;
    dec_val    = 1'b0;
    dec_tag    = '0;
    dec_dat    = '0;
    out_credit = 1'b0;
    @(negedge ireset);
    while (enc_got < WORDS || dec_got < WORDS) begin
      @(negedge iclk);
      cyc++;
      if (cyc > MAX_CYCLES) begin
        report_failure($sformatf("Timeout: %0d encoder and %0d decoder results in %0d cycles.",
                                 enc_got, dec_got, cyc));
      end
      take_result();
      drive_enc();
      drive_dec();
      drive_sink();
    end
    if (enc_returned != enc_got || dec_returned != dec_got) begin
      report_failure($sformatf("Credit pulses %0d and %0d do not match results %0d and %0d.",
                               enc_returned, dec_returned, enc_got, dec_got));
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/golay24_pkg.sv
source/golay_peer_if.sv
source/golay24_enc.sv
source/golay24_dec.sv
source/golay24_out_arb.sv
source/golay24_codec_top.sv
bench/tb_clock.sv
bench/golay24_tb_sva.sv
bench/golay24_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vgolay24_tb

.PHONY: all run clean

all: run

$(SIM): project.f $(wildcard source/*.sv source/*.svh bench/*.sv)
	verilator --binary --timing --assert -j 0 --timescale 1ns/10ps \
		--top-module golay24_tb -f project.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
